/* logic/dbgPkg.sv */
// Debug trace widths, APB register map, readout windows and analyzer state type

package dbgPkg;

  // *******************************************************************
  // Data path widths
  // *******************************************************************
  localparam int unsigned LANE_WIDTH       = 16;
  localparam int unsigned NUM_LANES        = 16;
  localparam int unsigned LANE_SEL_WIDTH   = 4;
  localparam int unsigned BUS_WIDTH        = 2 * LANE_WIDTH;
  localparam int unsigned TS_WIDTH         = 16;

  // Trace storage
  localparam int unsigned TRACE_DEPTH      = 16;
  localparam int unsigned TRACE_ADDR_WIDTH = 4;
  // Sample count needs one extra bit to reach TRACE_DEPTH
  localparam int unsigned COUNT_WIDTH      = TRACE_ADDR_WIDTH + 1;

  // APB port
  localparam int unsigned APB_ADDR_WIDTH   = 12;
  localparam int unsigned APB_DATA_WIDTH   = 32;

  // *******************************************************************
  // Register map
  // *******************************************************************
  localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL    = 'h000;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_MUXSEL  = 'h004;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_MASK    = 'h008;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_MATCH   = 'h00C;
  localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS  = 'h010;

  // Readout windows, one word per trace entry
  localparam logic [APB_ADDR_WIDTH-1:0] TRDATA_BASE = 'h100;
  localparam logic [APB_ADDR_WIDTH-1:0] TRTS_BASE   = 'h200;
  localparam int unsigned TRWIN_LSB = TRACE_ADDR_WIDTH + 2;

  // Field positions
  localparam int unsigned CTRL_ARM_BIT    = 0;
  localparam int unsigned CTRL_CLEAR_BIT  = 1;
  localparam int unsigned STATUS_CNT_LSB  = 4;

  // Analyzer state
  typedef enum logic [1:0] {
    CLA_IDLE    = 2'd0,
    CLA_ARMED   = 2'd1,
    CLA_TRACING = 2'd2,
    CLA_DONE    = 2'd3
  } claState_e;

endpackage

/* logic/dbgRegs.sv */
// APB register block with control, mux select, mask, match, status and trace readout window
`timescale 1ns/1ps

module dbgRegs import dbgPkg::*; (
  input  logic                        clk,
  input  logic                        i_rstN,
  input  logic [APB_ADDR_WIDTH-1:0]   i_paddr,
  input  logic                        i_psel,
  input  logic                        i_penable,
  input  logic                        i_pwrite,
  input  logic [APB_DATA_WIDTH-1:0]   i_pwdata,
  input  claState_e                   i_claState,
  input  logic [COUNT_WIDTH-1:0]      i_writeCount,
  input  logic [BUS_WIDTH-1:0]        i_rdData,
  input  logic [TS_WIDTH-1:0]         i_rdTs,
  output logic                        o_pready,
  output logic [APB_DATA_WIDTH-1:0]   o_prdata,
  output logic                        o_pslverr,
  output logic [LANE_SEL_WIDTH-1:0]   o_laneSel0,
  output logic [LANE_SEL_WIDTH-1:0]   o_laneSel1,
  output logic [BUS_WIDTH-1:0]        o_matchMask,
  output logic [BUS_WIDTH-1:0]        o_matchValue,
  output logic                        o_armPulse,
  output logic                        o_clearPulse,
  output logic [TRACE_ADDR_WIDTH-1:0] o_rdIndex
);

  logic                      access;
  logic                      wrAccess;
  logic                      rdAccess;
  logic                      hitCtrl;
  logic                      hitMuxSel;
  logic                      hitMask;
  logic                      hitMatch;
  logic                      hitStatus;
  logic                      hitData;
  logic                      hitTs;
  logic                      addrHit;
  logic [APB_DATA_WIDTH-1:0] statusWord;

  // *******************************************************************
  // Address decode
  // *******************************************************************
  assign access   = i_psel & i_penable;
  assign wrAccess = access & i_pwrite;
  assign rdAccess = access & ~i_pwrite;

  assign hitCtrl   = (i_paddr == REG_CTRL);
  assign hitMuxSel = (i_paddr == REG_MUXSEL);
  assign hitMask   = (i_paddr == REG_MASK);
  assign hitMatch  = (i_paddr == REG_MATCH);
  assign hitStatus = (i_paddr == REG_STATUS);

  // Windows cover TRACE_DEPTH aligned words each
  assign hitData = (i_paddr[APB_ADDR_WIDTH-1:TRWIN_LSB] ==
                    TRDATA_BASE[APB_ADDR_WIDTH-1:TRWIN_LSB]) && (i_paddr[1:0] == 2'b00);
  assign hitTs   = (i_paddr[APB_ADDR_WIDTH-1:TRWIN_LSB] ==
                    TRTS_BASE[APB_ADDR_WIDTH-1:TRWIN_LSB]) && (i_paddr[1:0] == 2'b00);

  assign addrHit = hitCtrl | hitMuxSel | hitMask | hitMatch | hitStatus | hitData | hitTs;

  // No wait states
  assign o_pready  = access;
  assign o_pslverr = access & ~addrHit;
  assign o_rdIndex = i_paddr[TRWIN_LSB-1:2];

  // *******************************************************************
  // Configuration registers and control pulses
  // *******************************************************************
  always_ff @(posedge clk) begin
    if (!i_rstN) begin
      o_laneSel0   <= '0;
      o_laneSel1   <= '0;
      o_matchMask  <= '0;
      o_matchValue <= '0;
      o_armPulse   <= 1'b0;
      o_clearPulse <= 1'b0;
    end else begin
      o_armPulse   <= wrAccess & hitCtrl & i_pwdata[CTRL_ARM_BIT];
      o_clearPulse <= wrAccess & hitCtrl & i_pwdata[CTRL_CLEAR_BIT];
      if (wrAccess && hitMuxSel) begin
        o_laneSel0 <= i_pwdata[LANE_SEL_WIDTH-1:0];
        o_laneSel1 <= i_pwdata[2*LANE_SEL_WIDTH-1:LANE_SEL_WIDTH];
      end
      if (wrAccess && hitMask) begin
        o_matchMask <= i_pwdata;
      end
      if (wrAccess && hitMatch) begin
        o_matchValue <= i_pwdata;
      end
    end
  end

  // *******************************************************************
  // Read data
  // *******************************************************************
  always_comb begin
    statusWord = '0;
    statusWord[1:0] = i_claState;
    statusWord[STATUS_CNT_LSB +: COUNT_WIDTH] = i_writeCount;
  end

  always_comb begin
    o_prdata = '0;
    if (rdAccess) begin
      if (hitMuxSel) begin
        o_prdata = {{(APB_DATA_WIDTH-2*LANE_SEL_WIDTH){1'b0}}, o_laneSel1, o_laneSel0};
      end else if (hitMask) begin
        o_prdata = o_matchMask;
      end else if (hitMatch) begin
        o_prdata = o_matchValue;
      end else if (hitStatus) begin
        o_prdata = statusWord;
      end else if (hitData) begin
        o_prdata = i_rdData;
      end else if (hitTs) begin
        o_prdata = {{(APB_DATA_WIDTH-TS_WIDTH){1'b0}}, i_rdTs};
      end
    end
  end

endmodule

/* logic/debugMux.sv */
// Debug multiplexer selecting two hardware lanes into the registered debug bus
`timescale 1ns/1ps

module debugMux import dbgPkg::*; (
  input  logic                                  clk,
  input  logic                                  i_rstN,
  input  logic [NUM_LANES-1:0][LANE_WIDTH-1:0]  i_hwLanes,
  input  logic [LANE_SEL_WIDTH-1:0]             i_laneSel0,
  input  logic [LANE_SEL_WIDTH-1:0]             i_laneSel1,
  output logic [BUS_WIDTH-1:0]                  o_debugBus
);

  logic [LANE_WIDTH-1:0] lowLane;
  logic [LANE_WIDTH-1:0] highLane;

  // Lane 0 feeds the low half, lane 1 the high half
  assign lowLane  = i_hwLanes[i_laneSel0];
  assign highLane = i_hwLanes[i_laneSel1];

  // One cycle of latency
  always_ff @(posedge clk) begin
    if (!i_rstN) begin
      o_debugBus <= '0;
    end else begin
      o_debugBus <= {highLane, lowLane};
    end
  end

endmodule

/* logic/logicAnalyzer.sv */
// Core logic analyzer with arm and masked match state machine and cross-trigger output
`timescale 1ns/1ps

module logicAnalyzer import dbgPkg::*; (
  input  logic                 clk,
  input  logic                 i_rstN,
  input  logic [BUS_WIDTH-1:0] i_debugBus,
  input  logic [BUS_WIDTH-1:0] i_matchMask,
  input  logic [BUS_WIDTH-1:0] i_matchValue,
  input  logic                 i_armPulse,
  input  logic                 i_clearPulse,
  input  logic                 i_xtriggerIn,
  input  logic                 i_traceDone,
  output logic [BUS_WIDTH-1:0] o_alignedBus,
  output logic                 o_sampleValid,
  output claState_e            o_state,
  output logic                 o_xtriggerOut
);

  claState_e state;
  logic      maskedMatch;
  logic      hit;

  // Only masked bits take part in the compare
  assign maskedMatch = ((i_debugBus & i_matchMask) == (i_matchValue & i_matchMask));
  assign hit         = maskedMatch | i_xtriggerIn;

  // Bus delayed to line up with the state, so the first traced sample is the hit
  always_ff @(posedge clk) begin
    o_alignedBus <= i_debugBus;
  end

  always_ff @(posedge clk) begin
    if (!i_rstN) begin
      state         <= CLA_IDLE;
      o_xtriggerOut <= 1'b0;
    end else begin
      o_xtriggerOut <= 1'b0;
      if (i_clearPulse) begin
        state <= CLA_IDLE;
      end else begin
        case (state)
          CLA_IDLE: begin
            if (i_armPulse) begin
              state <= CLA_ARMED;
            end
          end
          CLA_ARMED: begin
            if (hit) begin
              state         <= CLA_TRACING;
              o_xtriggerOut <= 1'b1;
            end
          end
          CLA_TRACING: begin
            if (i_traceDone) begin
              state <= CLA_DONE;
            end
          end
          // Held until software clears
          default: begin
            state <= state;
          end
        endcase
      end
    end
  end

  assign o_sampleValid = (state == CLA_TRACING);
  assign o_state       = state;

endmodule

/* logic/traceCapture.sv */
// Trace capture with timestamp counter, sample counting and buffer write generation
`timescale 1ns/1ps

module traceCapture import dbgPkg::*; (
  input  logic                        clk,
  input  logic                        i_rstN,
  input  logic                        i_timeTick,
  input  logic                        i_clearPulse,
  input  logic [BUS_WIDTH-1:0]        i_alignedBus,
  input  logic                        i_sampleValid,
  output logic                        o_wrEn,
  output logic [TRACE_ADDR_WIDTH-1:0] o_wrIndex,
  output logic [BUS_WIDTH-1:0]        o_wrData,
  output logic [TS_WIDTH-1:0]         o_wrTs,
  output logic [COUNT_WIDTH-1:0]      o_writeCount,
  output logic                        o_traceDone
);

  logic [COUNT_WIDTH-1:0] writeCount;
  logic [TS_WIDTH-1:0]    timeStamp;

  // Sample written at the next edge with the current timestamp
  assign o_wrEn       = i_sampleValid;
  assign o_wrIndex    = writeCount[TRACE_ADDR_WIDTH-1:0];
  assign o_wrData     = i_alignedBus;
  assign o_wrTs       = timeStamp;
  assign o_writeCount = writeCount;

  // Last entry of the trace
  assign o_traceDone = o_wrEn & (writeCount == COUNT_WIDTH'(TRACE_DEPTH - 1));

  always_ff @(posedge clk) begin
    if (!i_rstN || i_clearPulse) begin
      writeCount <= '0;
      timeStamp  <= '0;
    end else begin
      if (o_wrEn) begin
        writeCount <= writeCount + COUNT_WIDTH'(1);
      end
      if (i_timeTick) begin
        timeStamp <= timeStamp + TS_WIDTH'(1);
      end
    end
  end

endmodule

/* logic/traceBuffer.sv */
// Trace buffer storage for sample data and timestamps with combinational read port
`timescale 1ns/1ps

module traceBuffer import dbgPkg::*; (
  input  logic                        clk,
  input  logic                        i_wrEn,
  input  logic [TRACE_ADDR_WIDTH-1:0] i_wrIndex,
  input  logic [BUS_WIDTH-1:0]        i_wrData,
  input  logic [TS_WIDTH-1:0]         i_wrTs,
  input  logic [TRACE_ADDR_WIDTH-1:0] i_rdIndex,
  output logic [BUS_WIDTH-1:0]        o_rdData,
  output logic [TS_WIDTH-1:0]         o_rdTs
);

  // Data and timestamp share one index
  logic [BUS_WIDTH-1:0] dataMem [TRACE_DEPTH];
  logic [TS_WIDTH-1:0]  tsMem   [TRACE_DEPTH];

  always_ff @(posedge clk) begin
    if (i_wrEn) begin
      dataMem[i_wrIndex] <= i_wrData;
      tsMem[i_wrIndex]   <= i_wrTs;
    end
  end

  // Readout for the APB windows
  assign o_rdData = dataMem[i_rdIndex];
  assign o_rdTs   = tsMem[i_rdIndex];

endmodule

/* logic/dbgTop.sv */
// Debug trace top level with register block, debug mux, analyzer, capture and buffer
`timescale 1ns/1ps

module dbgTop import dbgPkg::*; (
  input  logic                                  clk,
  input  logic                                  i_rstN,
  input  logic [NUM_LANES-1:0][LANE_WIDTH-1:0]  i_hwLanes,
  input  logic                                  i_timeTick,
  input  logic                                  i_xtriggerIn,
  output logic                                  o_xtriggerOut,
  input  logic [APB_ADDR_WIDTH-1:0]             i_paddr,
  input  logic                                  i_psel,
  input  logic                                  i_penable,
  input  logic                                  i_pwrite,
  input  logic [APB_DATA_WIDTH-1:0]             i_pwdata,
  output logic                                  o_pready,
  output logic [APB_DATA_WIDTH-1:0]             o_prdata,
  output logic                                  o_pslverr
);

  // Configuration
  logic [LANE_SEL_WIDTH-1:0]   laneSel0;
  logic [LANE_SEL_WIDTH-1:0]   laneSel1;
  logic [BUS_WIDTH-1:0]        matchMask;
  logic [BUS_WIDTH-1:0]        matchValue;
  logic                        armPulse;
  logic                        clearPulse;

  // Trace path
  logic [BUS_WIDTH-1:0]        debugBus;
  logic [BUS_WIDTH-1:0]        alignedBus;
  logic                        sampleValid;
  claState_e                   claState;
  logic                        traceDone;
  logic                        wrEn;
  logic [TRACE_ADDR_WIDTH-1:0] wrIndex;
  logic [BUS_WIDTH-1:0]        wrData;
  logic [TS_WIDTH-1:0]         wrTs;
  logic [COUNT_WIDTH-1:0]      writeCount;

  // Readout
  logic [TRACE_ADDR_WIDTH-1:0] rdIndex;
  logic [BUS_WIDTH-1:0]        rdData;
  logic [TS_WIDTH-1:0]         rdTs;

  // *******************************************************************
  // Register block
  // *******************************************************************
  dbgRegs uRegs (
    .clk          (clk),
    .i_rstN       (i_rstN),
    .i_paddr      (i_paddr),
    .i_psel       (i_psel),
    .i_penable    (i_penable),
    .i_pwrite     (i_pwrite),
    .i_pwdata     (i_pwdata),
    .i_claState   (claState),
    .i_writeCount (writeCount),
    .i_rdData     (rdData),
    .i_rdTs       (rdTs),
    .o_pready     (o_pready),
    .o_prdata     (o_prdata),
    .o_pslverr    (o_pslverr),
    .o_laneSel0   (laneSel0),
    .o_laneSel1   (laneSel1),
    .o_matchMask  (matchMask),
    .o_matchValue (matchValue),
    .o_armPulse   (armPulse),
    .o_clearPulse (clearPulse),
    .o_rdIndex    (rdIndex)
  );

  // *******************************************************************
  // Trace pipeline
  // *******************************************************************
  debugMux uMux (
    .clk        (clk),
    .i_rstN     (i_rstN),
    .i_hwLanes  (i_hwLanes),
    .i_laneSel0 (laneSel0),
    .i_laneSel1 (laneSel1),
    .o_debugBus (debugBus)
  );

  logicAnalyzer uCla (
    .clk           (clk),
    .i_rstN        (i_rstN),
    .i_debugBus    (debugBus),
    .i_matchMask   (matchMask),
    .i_matchValue  (matchValue),
    .i_armPulse    (armPulse),
    .i_clearPulse  (clearPulse),
    .i_xtriggerIn  (i_xtriggerIn),
    .i_traceDone   (traceDone),
    .o_alignedBus  (alignedBus),
    .o_sampleValid (sampleValid),
    .o_state       (claState),
    .o_xtriggerOut (o_xtriggerOut)
  );

  traceCapture uCapture (
    .clk           (clk),
    .i_rstN        (i_rstN),
    .i_timeTick    (i_timeTick),
    .i_clearPulse  (clearPulse),
    .i_alignedBus  (alignedBus),
    .i_sampleValid (sampleValid),
    .o_wrEn        (wrEn),
    .o_wrIndex     (wrIndex),
    .o_wrData      (wrData),
    .o_wrTs        (wrTs),
    .o_writeCount  (writeCount),
    .o_traceDone   (traceDone)
  );

  traceBuffer uBuffer (
    .clk       (clk),
    .i_wrEn    (wrEn),
    .i_wrIndex (wrIndex),
    .i_wrData  (wrData),
    .i_wrTs    (wrTs),
    .i_rdIndex (rdIndex),
    .o_rdData  (rdData),
    .o_rdTs    (rdTs)
  );

endmodule

/* tb/tbTasks.svh */
// APB access tasks, trace helpers and directed test tasks for the debug trace testbench
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// *******************************************************************
// Expected values and checking
// *******************************************************************
function automatic logic [BUS_WIDTH-1:0] busValue(input logic [LANE_WIDTH-1:0] cnt,
                                                  input logic [LANE_SEL_WIDTH-1:0] sel0,
                                                  input logic [LANE_SEL_WIDTH-1:0] sel1);
  logic [LANE_WIDTH-1:0] lowHalf;
  logic [LANE_WIDTH-1:0] highHalf;
  lowHalf  = cnt + {4'd0, sel0, 8'h00};
  highHalf = cnt + {4'd0, sel1, 8'h00};
  return {highHalf, lowHalf};
endfunction

// Both halves advance on their own
function automatic logic [BUS_WIDTH-1:0] busStep(input logic [BUS_WIDTH-1:0] start,
                                                 input int step);
  return {start[31:16] + 16'(step), start[15:0] + 16'(step)};
endfunction

task automatic expectEqual(input logic [31:0] got, input logic [31:0] exp, input string what);
  checkCount = checkCount + 1;
  assert (got === exp) else begin
    $display("ERR %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    errCount = errCount + 1;
  end
endtask

task automatic reportTest(input string name, input int errBefore);
  $display("Test %s done with %0d errors", name, errCount - errBefore);
endtask

// *******************************************************************
// APB access
// *******************************************************************
task automatic apbAccess(input logic write, input logic [APB_ADDR_WIDTH-1:0] addr,
                         input logic [31:0] wdata, output logic [31:0] rdata,
                         output logic err);
  @(negedge clk);
  paddr   = addr;
  pwrite  = write;
  pwdata  = wdata;
  psel    = 1'b1;
  penable = 1'b0;
  @(negedge clk);
  penable = 1'b1;
  #(SAMPLE_DELAY);
  assert (pready) else begin
    $display("APB slave did not raise PREADY in the access phase at %0t ns", $time);
    errCount = errCount + 1;
  end
  rdata = prdata;
  err   = pslverr;
  @(negedge clk);
  psel    = 1'b0;
  penable = 1'b0;
  pwrite  = 1'b0;
endtask

task automatic apbWrite(input logic [APB_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
  logic [31:0] unused;
  logic        err;
  apbAccess(1'b1, addr, data, unused, err);
  expectEqual(32'(err), 32'd0, "PSLVERR on write");
endtask

task automatic apbRead(input logic [APB_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
  logic err;
  apbAccess(1'b0, addr, 32'd0, data, err);
  expectEqual(32'(err), 32'd0, "PSLVERR on read");
endtask

// *******************************************************************
// Trace helpers
// *******************************************************************
task automatic startTrace(input logic [3:0] sel0, input logic [3:0] sel1,
                          input logic [31:0] mask, output logic [31:0] firstBus);
  logic [LANE_WIDTH-1:0] target;
  logic [31:0]           junk;
  apbWrite(REG_CTRL, 32'h2);
  apbWrite(REG_MUXSEL, {24'd0, sel1, sel0});
  apbWrite(REG_MASK, mask);
  // Far enough ahead that the analyzer is armed first
  target   = laneCnt + 16'd40;
  junk     = $random(seed);
  firstBus = busValue(target, sel0, sel1);
  apbWrite(REG_MATCH, (firstBus & mask) | (junk & ~mask));
  apbWrite(REG_CTRL, 32'h1);
endtask

// Lanes 3 and 7 always differ by 0x400 so a match with equal halves never hits
task automatic armWithoutHit();
  apbWrite(REG_CTRL, 32'h2);
  apbWrite(REG_MUXSEL, 32'h73);
  apbWrite(REG_MASK, 32'hFFFF_FFFF);
  apbWrite(REG_MATCH, 32'h5A5A_5A5A);
  apbWrite(REG_CTRL, 32'h1);
endtask

task automatic waitTraceDone();
  logic [31:0] status;
  int          polls;
  polls = 0;
  apbRead(REG_STATUS, status);
  while (status[1:0] != CLA_DONE && polls < POLL_LIMIT) begin
    apbRead(REG_STATUS, status);
    polls = polls + 1;
  end
  assert (status[1:0] == CLA_DONE) else begin
    $display("Trace did not reach the done state after %0d status reads", polls);
    errCount = errCount + 1;
  end
  expectEqual(status, {23'd0, 5'(TRACE_DEPTH), 2'b00, CLA_DONE}, "status after trace");
endtask

task automatic readTrace();
  logic [31:0] tsWord;
  for (int i = 0; i < TRACE_DEPTH; i++) begin
    apbRead(TRDATA_BASE + 12'(i * 4), traceData[i]);
    apbRead(TRTS_BASE + 12'(i * 4), tsWord);
    traceTs[i] = tsWord[15:0];
  end
endtask

task automatic checkConsecutive(input logic [31:0] start, input string name);
  for (int i = 0; i < TRACE_DEPTH; i++) begin
    expectEqual(traceData[i], busStep(start, i), $sformatf("%s entry %0d", name, i));
  end
endtask

// *******************************************************************
// Directed tests
// *******************************************************************
task automatic testRegReadback();
  int          errBefore;
  logic [31:0] rdata;
  logic [31:0] maskVal;
  logic [31:0] matchVal;
  logic        err;
  errBefore = errCount;
  maskVal   = $random(seed);
  matchVal  = $random(seed);
  apbRead(REG_STATUS, rdata);
  expectEqual(rdata, 32'd0, "status after reset");
  apbWrite(REG_MUXSEL, 32'h0000_00A5);
  apbRead(REG_MUXSEL, rdata);
  expectEqual(rdata, 32'h0000_00A5, "MUXSEL readback");
  apbWrite(REG_MASK, maskVal);
  apbRead(REG_MASK, rdata);
  expectEqual(rdata, maskVal, "MASK readback");
  apbWrite(REG_MATCH, matchVal);
  apbRead(REG_MATCH, rdata);
  expectEqual(rdata, matchVal, "MATCH readback");
  apbAccess(1'b0, 12'h020, 32'd0, rdata, err);
  expectEqual(32'(err), 32'd1, "PSLVERR on read of 0x020");
  apbAccess(1'b1, 12'h300, 32'hFFFF_FFFF, rdata, err);
  expectEqual(32'(err), 32'd1, "PSLVERR on write to 0x300");
  reportTest("register readback", errBefore);
endtask

task automatic testArmMatch();
  int          errBefore;
  logic [3:0]  sel0;
  logic [3:0]  sel1;
  logic [31:0] firstBus;
  errBefore = errCount;
  sel0 = 4'($random(seed));
  sel1 = 4'($random(seed));
  startTrace(sel0, sel1, 32'hFFFF_FFFF, firstBus);
  waitTraceDone();
  readTrace();
  checkConsecutive(firstBus, "arm and match");
  reportTest("arm and match", errBefore);
endtask

task automatic testMask();
  int          errBefore;
  logic [3:0]  sel0;
  logic [3:0]  sel1;
  logic [31:0] firstBus;
  errBefore = errCount;
  sel0 = 4'($random(seed));
  sel1 = 4'($random(seed));
  startTrace(sel0, sel1, 32'h0000_FFFF, firstBus);
  waitTraceDone();
  readTrace();
  expectEqual({16'd0, traceData[0][15:0]}, {16'd0, firstBus[15:0]}, "low half of first entry");
  checkConsecutive(firstBus, "mask");
  reportTest("mask", errBefore);
endtask

task automatic testCrossTrigger();
  int          errBefore;
  int          pulsesBefore;
  logic [31:0] status;
  logic [15:0] laneGap;
  errBefore    = errCount;
  pulsesBefore = xtrigHighCycles;
  armWithoutHit();
  apbRead(REG_STATUS, status);
  expectEqual(status, 32'h1, "status while armed");
  @(negedge clk);
  xtriggerIn = 1'b1;
  @(negedge clk);
  xtriggerIn = 1'b0;
  waitTraceDone();
  readTrace();
  laneGap = traceData[0][31:16] - traceData[0][15:0];
  expectEqual({16'd0, laneGap}, 32'h400, "lane offset of first entry");
  // Later entries follow the first one
  for (int i = 1; i < TRACE_DEPTH; i++) begin
    expectEqual(traceData[i], busStep(traceData[0], i),
                $sformatf("cross-trigger entry %0d", i));
  end
  expectEqual(xtrigHighCycles - pulsesBefore, 32'd1, "cross-trigger output cycles");
  reportTest("cross-trigger", errBefore);
endtask

task automatic testTimestamps();
  int          errBefore;
  logic [3:0]  sel0;
  logic [3:0]  sel1;
  logic [31:0] firstBus;
  errBefore = errCount;
  sel0 = 4'($random(seed));
  sel1 = 4'($random(seed));
  @(negedge clk);
  timeTick = 1'b1;
  startTrace(sel0, sel1, 32'hFFFF_FFFF, firstBus);
  waitTraceDone();
  readTrace();
  for (int i = 1; i < TRACE_DEPTH; i++) begin
    expectEqual({16'd0, traceTs[i]}, {16'd0, traceTs[0] + 16'(i)},
                $sformatf("timestamp with tick, entry %0d", i));
  end
  @(negedge clk);
  timeTick = 1'b0;
  startTrace(sel0, sel1, 32'hFFFF_FFFF, firstBus);
  waitTraceDone();
  readTrace();
  for (int i = 0; i < TRACE_DEPTH; i++) begin
    expectEqual({16'd0, traceTs[i]}, 32'd0, $sformatf("timestamp without tick, entry %0d", i));
  end
  reportTest("timestamps", errBefore);
endtask

task automatic testClear();
  int          errBefore;
  int          pulsesBefore;
  logic [31:0] status;
  errBefore    = errCount;
  pulsesBefore = xtrigHighCycles;
  armWithoutHit();
  repeat (20) @(negedge clk);
  apbRead(REG_STATUS, status);
  expectEqual(status, 32'h1, "status armed without a hit");
  apbWrite(REG_CTRL, 32'h2);
  apbRead(REG_STATUS, status);
  expectEqual(status, 32'h0, "status after clear");
  expectEqual(xtrigHighCycles - pulsesBefore, 32'd0, "cross-trigger output cycles");
  reportTest("clear", errBefore);
endtask

`endif

/* tb/tbDbgTop.sv */
// Testbench top with clock, reset, lane stimulus, DUT instance, cycle limit and final report
`timescale 1ns/1ps

module tbDbgTop import dbgPkg::*; ();

  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 8;
  localparam int MAX_CYCLES   = 3000;
  localparam int SAMPLE_DELAY = 10;
  localparam int POLL_LIMIT   = 200;

  logic                                 clk;
  logic                                 rstN;
  logic [NUM_LANES-1:0][LANE_WIDTH-1:0] hwLanes;
  logic                                 timeTick;
  logic                                 xtriggerIn;
  logic                                 xtriggerOut;
  logic [APB_ADDR_WIDTH-1:0]            paddr;
  logic                                 psel;
  logic                                 penable;
  logic                                 pwrite;
  logic [APB_DATA_WIDTH-1:0]            pwdata;
  logic                                 pready;
  logic [APB_DATA_WIDTH-1:0]            prdata;
  logic                                 pslverr;

  logic [LANE_WIDTH-1:0] laneCnt = '0;
  integer                seed = 19;
  int                    errCount = 0;
  int                    checkCount = 0;
  int                    cycleCount = 0;
  int                    xtrigHighCycles = 0;

  // Last trace read back over APB
  logic [BUS_WIDTH-1:0] traceData [TRACE_DEPTH];
  logic [TS_WIDTH-1:0]  traceTs   [TRACE_DEPTH];

  `include "tbTasks.svh"

  dbgTop UUT (
    .clk           (clk),
    .i_rstN        (rstN),
    .i_hwLanes     (hwLanes),
    .i_timeTick    (timeTick),
    .i_xtriggerIn  (xtriggerIn),
    .o_xtriggerOut (xtriggerOut),
    .i_paddr       (paddr),
    .i_psel        (psel),
    .i_penable     (penable),
    .i_pwrite      (pwrite),
    .i_pwdata      (pwdata),
    .o_pready      (pready),
    .o_prdata      (prdata),
    .o_pslverr     (pslverr)
  );

  // *******************************************************************
  // Clock, lane stimulus and monitors
  // *******************************************************************
  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  always @(negedge clk) begin
    laneCnt <= laneCnt + 16'd1;
  end

  // Lane k runs the shared counter offset by k x 0x100
  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      hwLanes[k] = laneCnt + LANE_WIDTH'(k * 256);
    end
  end

  always @(negedge clk) begin
    if (rstN && xtriggerOut) begin
      xtrigHighCycles <= xtrigHighCycles + 1;
    end
  end

  initial begin
    while (cycleCount < MAX_CYCLES) begin
      @(posedge clk);
      cycleCount = cycleCount + 1;
    end
    $display("Timeout: the run did not complete within %0d clock cycles", MAX_CYCLES);
    $display("Finished with errors");
    $finish;
  end

  // *******************************************************************
  // Test sequence
  // *******************************************************************
  initial begin
    rstN       = 1'b0;
    timeTick   = 1'b0;
    xtriggerIn = 1'b0;
    paddr      = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    pwdata     = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;

    testRegReadback();
    testArmMatch();
    testMask();
    testCrossTrigger();
    testTimestamps();
    testClear();

    $display("Summary: 6 tests, %0d checks, %0d errors", checkCount, errCount);
    if (errCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+tb
logic/dbgPkg.sv
logic/dbgRegs.sv
logic/debugMux.sv
logic/logicAnalyzer.sv
logic/traceCapture.sv
logic/traceBuffer.sv
logic/dbgTop.sv
tb/tbDbgTop.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the debug trace testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f list.f --top-module tbDbgTop; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/VtbDbgTop)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qxF "Finished with no errors" <<< "$output"; then
  exit 0
fi

echo "Simulation reported a failure"
exit 1
